//--- hw/clkcfg_reg_pkg.sv
package clkcfg_reg_pkg;

  // Register bus shape
  localparam int REG_W      = 8;           // Bus data width
  localparam int REG_ADDR_W = 8;           // Bus address width
  localparam int BYTECNT_W  = 7;           // Byte counter width
  localparam int DRP_BYTES  = 2;           // Bytes per DRP word on the bus

  // MMCM0 register pair
  localparam logic [REG_ADDR_W-1:0] MMCM0_DRP_ADDR = 8'h60;  // Address and command
  localparam logic [REG_ADDR_W-1:0] MMCM0_DRP_DATA = 8'h61;  // Write data and read hold

  // MMCM1 register pair
  localparam logic [REG_ADDR_W-1:0] MMCM1_DRP_ADDR = 8'h62;  // Address and command
  localparam logic [REG_ADDR_W-1:0] MMCM1_DRP_DATA = 8'h63;  // Write data and read hold

  // Shared status register
  localparam logic [REG_ADDR_W-1:0] DRP_STATUS = 8'h64;

  // Done bit positions inside DRP_STATUS
  localparam int STATUS_MMCM0_BIT = 0;
  localparam int STATUS_MMCM1_BIT = 1;

  // Upper status bits are tied low
  localparam int STATUS_USED = 2;

endpackage

//--- hw/clkcfg_drp_pkg.sv
package clkcfg_drp_pkg;

  // DRP port widths of the clock manager
  localparam int DRP_ADDR_W = 7;           // 128 config words
  localparam int DRP_DATA_W = 16;          // One DRP word

  // Configuration store model
  localparam int STORE_DEPTH   = 128;      // Words per store
  localparam int STORE_LATENCY = 2;        // DEN to DRDY in cycles

  // Command byte written to the DRP address register
  //   bit 7    write when set, read when clear
  //   bits 6:0 DRP address
  localparam int DRP_WRITE_BIT = 7;

endpackage

//--- hw/drp_if.sv
`timescale 1ns/1ps

// One DRP port between a bridge and a clock manager target
interface drp_if;
  import clkcfg_drp_pkg::*;

  logic [DRP_ADDR_W-1:0] addr;             // Word address
  logic                  den;              // Access strobe, one cycle
  logic                  dwe;              // Write enable, valid with den
  logic [DRP_DATA_W-1:0] din;              // Write data to target
  logic [DRP_DATA_W-1:0] dout;             // Read data from target
  logic                  drdy;             // Access done, one cycle

  modport bridge (                         // Register side master
    output addr, den, dwe, din,
    input  dout, drdy
  );

  modport target (                         // Clock manager side
    input  addr, den, dwe, din,
    output dout, drdy
  );

  modport monitor (                        // Status tracking only
    input den, drdy
  );

endinterface

//--- hw/reg_mmcm_drp.sv
`timescale 1ns/1ps

// Register to DRP bridge for one clock manager
// Write path: load DATA_REG bytes, then write ADDR_REG with bit 7 set
// Read path: write ADDR_REG with bit 7 clear, poll status, read DATA_REG
module reg_mmcm_drp #(
  parameter logic [clkcfg_reg_pkg::REG_ADDR_W-1:0] ADDR_REG = clkcfg_reg_pkg::MMCM0_DRP_ADDR,
  parameter logic [clkcfg_reg_pkg::REG_ADDR_W-1:0] DATA_REG = clkcfg_reg_pkg::MMCM0_DRP_DATA
) (
  input  logic                                 clk_usb,
  input  logic                                 reset_i,
  input  logic [clkcfg_reg_pkg::REG_ADDR_W-1:0] reg_address,  // Bus address
  input  logic [clkcfg_reg_pkg::BYTECNT_W-1:0]  reg_bytecnt,  // Byte within register
  input  logic [clkcfg_reg_pkg::REG_W-1:0]      reg_datai,    // Bus write data
  input  logic                                 reg_read,     // Read level
  input  logic                                 reg_write,    // Write level
  output logic [clkcfg_reg_pkg::REG_W-1:0]      rd_byte,      // Registered read byte
  drp_if.bridge                                drp
);
  import clkcfg_reg_pkg::*;
  import clkcfg_drp_pkg::*;

  logic                  byte_ok;          // Byte count inside the DRP word
  logic                  byte_sel;         // Low or high byte
  logic                  addr_wr;          // Command write this cycle
  logic                  data_wr;          // Data byte write this cycle
  logic                  addr_rd;          // Address readback
  logic                  data_rd;          // Read hold readback
  logic                  rd_cmd;           // Last command was a read
  logic [DRP_DATA_W-1:0] rd_hold;          // Captured dout

  assign byte_ok  = (reg_bytecnt < BYTECNT_W'(DRP_BYTES));
  assign byte_sel = reg_bytecnt[0];
  assign addr_wr  = reg_write && (reg_address == ADDR_REG);
  assign data_wr  = reg_write && (reg_address == DATA_REG) && byte_ok;
  assign addr_rd  = reg_read && (reg_address == ADDR_REG);
  assign data_rd  = reg_read && (reg_address == DATA_REG) && byte_ok;

  // Command register, den is high for exactly the cycle after the write
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      drp.den  <= 1'b0;
      drp.dwe  <= 1'b0;
      drp.addr <= '0;
      rd_cmd   <= 1'b0;
    end else begin
      drp.den <= addr_wr;                                    // One cycle strobe
      drp.dwe <= addr_wr && reg_datai[DRP_WRITE_BIT];        // Only with den
      if (addr_wr) begin
        drp.addr <= reg_datai[DRP_ADDR_W-1:0];               // Low 7 bits
        rd_cmd   <= !reg_datai[DRP_WRITE_BIT];               // Remember direction
      end
    end
  end

  // Write data assembled byte by byte, no DRP traffic
  always_ff @(posedge clk_usb) begin
    if (data_wr) begin
      drp.din[byte_sel*REG_W +: REG_W] <= reg_datai;
    end
  end

  // Read hold, a later command may still see an earlier response land here
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      rd_hold <= '0;
    end else if (drp.drdy && rd_cmd) begin
      rd_hold <= drp.dout;                                   // Valid in drdy cycle
    end
  end

  // Readback byte, zero unless this bridge is addressed
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      rd_byte <= '0;
    end else if (addr_rd) begin
      rd_byte <= {1'b0, drp.addr};                           // Command bit reads 0
    end else if (data_rd) begin
      rd_byte <= rd_hold[byte_sel*REG_W +: REG_W];
    end else begin
      rd_byte <= '0;                                         // Idle bus reads 0
    end
  end

endmodule

//--- hw/drp_cfg_store.sv
`timescale 1ns/1ps

// Configuration word store with clock manager DRP timing
// drdy follows every den after STORE_LATENCY cycles
module drp_cfg_store (
  input  logic  clk_usb,
  input  logic  reset_i,
  drp_if.target drp
);
  import clkcfg_drp_pkg::*;

  logic [DRP_DATA_W-1:0]    mem [STORE_DEPTH];  // Config words
  logic [STORE_LATENCY-1:0] lat_sr;             // In-flight access pipe
  logic [DRP_ADDR_W-1:0]    rd_addr;            // Address of latest access
  logic                     drdy_q;             // Response strobe

  // Word array, cleared to zero on reset
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      for (int i = 0; i < STORE_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (drp.den && drp.dwe) begin
      mem[drp.addr] <= drp.din;                 // Write at den
    end
  end

  // Latency pipe, a new den does not cancel one in flight
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      lat_sr <= '0;
    end else begin
      lat_sr <= (lat_sr << 1) | STORE_LATENCY'(drp.den);
    end
  end

  assign drdy_q = lat_sr[STORE_LATENCY-1];      // Pulse at end of pipe

  // Address captured at den, later den restarts it
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      rd_addr <= '0;
    end else if (drp.den) begin
      rd_addr <= drp.addr;
    end
  end

  assign drp.drdy = drdy_q;
  // Word shows only in the drdy cycle
  assign drp.dout = drdy_q ? mem[rd_addr] : '0;

endmodule

//--- hw/reg_readback_merge.sv
`timescale 1ns/1ps

// Readback merge and DRP status register
module reg_readback_merge (
  input  logic                                 clk_usb,
  input  logic                                 reset_i,
  input  logic [clkcfg_reg_pkg::REG_ADDR_W-1:0] reg_address,  // Bus address
  input  logic                                 reg_read,     // Read level
  input  logic [clkcfg_reg_pkg::REG_W-1:0]      rd_byte0,     // MMCM0 bridge byte
  input  logic [clkcfg_reg_pkg::REG_W-1:0]      rd_byte1,     // MMCM1 bridge byte
  drp_if.monitor                               drp0,
  drp_if.monitor                               drp1,
  output logic [clkcfg_reg_pkg::REG_W-1:0]      reg_datao     // To USB front end
);
  import clkcfg_reg_pkg::*;

  logic [STATUS_USED-1:0] done;            // One bit per clock manager
  logic [REG_W-1:0]       status_byte;     // Registered status readback

  // Done bits, a new den wins over a late drdy
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      done <= '0;
    end else begin
      if (drp0.den)       done[STATUS_MMCM0_BIT] <= 1'b0;
      else if (drp0.drdy) done[STATUS_MMCM0_BIT] <= 1'b1;
      if (drp1.den)       done[STATUS_MMCM1_BIT] <= 1'b0;
      else if (drp1.drdy) done[STATUS_MMCM1_BIT] <= 1'b1;
    end
  end

  // Status readback, upper bits zero
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      status_byte <= '0;
    end else if (reg_read && (reg_address == DRP_STATUS)) begin
      status_byte <= REG_W'(done);
    end else begin
      status_byte <= '0;
    end
  end

  // Only the addressed source is nonzero
  assign reg_datao = rd_byte0 | rd_byte1 | status_byte;

endmodule

//--- hw/clkcfg_top.sv
`timescale 1ns/1ps

// Clock configuration register block
// Two DRP bridges side by side, each with its own config store
module clkcfg_top (
  input  logic                                 clk_usb,
  input  logic                                 reset_i,
  input  logic [clkcfg_reg_pkg::REG_ADDR_W-1:0] reg_address,  // Register address
  input  logic [clkcfg_reg_pkg::BYTECNT_W-1:0]  reg_bytecnt,  // Byte select
  input  logic [clkcfg_reg_pkg::REG_W-1:0]      reg_datai,    // Write data
  input  logic                                 reg_read,     // Read level
  input  logic                                 reg_write,    // Write level
  output logic [clkcfg_reg_pkg::REG_W-1:0]      reg_datao     // Read data
);
  import clkcfg_reg_pkg::*;

  logic [REG_W-1:0] rd_byte0;              // MMCM0 bridge readback
  logic [REG_W-1:0] rd_byte1;              // MMCM1 bridge readback

  // DRP ports
  drp_if drp0 ();                          // MMCM0
  drp_if drp1 ();                          // MMCM1

  // MMCM0 bridge at 0x60/0x61
  reg_mmcm_drp #(
    .ADDR_REG (MMCM0_DRP_ADDR),
    .DATA_REG (MMCM0_DRP_DATA)
  ) u_bridge0 (
    .clk_usb     (clk_usb),
    .reset_i     (reset_i),
    .reg_address (reg_address),
    .reg_bytecnt (reg_bytecnt),
    .reg_datai   (reg_datai),
    .reg_read    (reg_read),
    .reg_write   (reg_write),
    .rd_byte     (rd_byte0),
    .drp         (drp0.bridge)
  );

  // MMCM1 bridge at 0x62/0x63
  reg_mmcm_drp #(
    .ADDR_REG (MMCM1_DRP_ADDR),
    .DATA_REG (MMCM1_DRP_DATA)
  ) u_bridge1 (
    .clk_usb     (clk_usb),
    .reset_i     (reset_i),
    .reg_address (reg_address),
    .reg_bytecnt (reg_bytecnt),
    .reg_datai   (reg_datai),
    .reg_read    (reg_read),
    .reg_write   (reg_write),
    .rd_byte     (rd_byte1),
    .drp         (drp1.bridge)
  );

  // Config stores in place of the clock managers
  drp_cfg_store u_store0 (
    .clk_usb (clk_usb),
    .reset_i (reset_i),
    .drp     (drp0.target)
  );

  drp_cfg_store u_store1 (
    .clk_usb (clk_usb),
    .reset_i (reset_i),
    .drp     (drp1.target)
  );

  // Readback OR and status register
  reg_readback_merge u_merge (
    .clk_usb     (clk_usb),
    .reset_i     (reset_i),
    .reg_address (reg_address),
    .reg_read    (reg_read),
    .rd_byte0    (rd_byte0),
    .rd_byte1    (rd_byte1),
    .drp0        (drp0.monitor),
    .drp1        (drp1.monitor),
    .reg_datao   (reg_datao)
  );

endmodule

//--- verif/clkcfg_tb.sv
`timescale 1ns/1ps

// Testbench for the clock configuration register block
module clkcfg_tb;
  import clkcfg_reg_pkg::*;

  localparam int DONE_TIMEOUT = 20;        // Status polls before giving up
  localparam int RAND_ROUNDS  = 8;         // Random accesses per clock manager

  logic                  clk_usb;
  logic                  reset_i;
  logic [REG_ADDR_W-1:0] reg_address;
  logic [BYTECNT_W-1:0]  reg_bytecnt;
  logic [REG_W-1:0]      reg_datai;
  logic                  reg_read;
  logic                  reg_write;
  logic [REG_W-1:0]      reg_datao;

  logic [15:0] lfsr = 16'd85;              // Stimulus LFSR state
  logic [15:0] model [2][128];             // Expected store contents
  logic [7:0]  written [$];                // {mmcm, drp addr} of every write

  clkcfg_top UUT (
    .clk_usb     (clk_usb),
    .reset_i     (reset_i),
    .reg_address (reg_address),
    .reg_bytecnt (reg_bytecnt),
    .reg_datai   (reg_datai),
    .reg_read    (reg_read),
    .reg_write   (reg_write),
    .reg_datao   (reg_datao)
  );

  always #5 clk_usb = ~clk_usb;            // 100 MHz

  // Bus idles at zero unless the previous cycle was a read
  assert property (@(posedge clk_usb) disable iff (reset_i)
                   $past(reg_read) || (reg_datao == '0))
    else begin
      $display("[FAIL] t=%0t reg_datao expected 00 got %02h (no read in previous cycle)",
               $time, $sampled(reg_datao));
      fail_run();
    end

  task automatic fail_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  // Galois form with taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);              // One step per bit
      val  = {val[14:0], lfsr[0]};
    end
  endtask

  function automatic logic [7:0] addr_reg_of(input bit idx);
    return idx ? MMCM1_DRP_ADDR : MMCM0_DRP_ADDR;
  endfunction

  function automatic logic [7:0] data_reg_of(input bit idx);
    return idx ? MMCM1_DRP_DATA : MMCM0_DRP_DATA;
  endfunction

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    assert (got === exp)
      else begin
        $display("[FAIL] t=%0t %s expected %02h got %02h", $time, name, exp, got);
        fail_run();
      end
  endtask

  task automatic idle_cycle();
    @(posedge clk_usb);
    #1;
  endtask

  // One byte write with the level held for a single cycle
  task automatic write_reg(input logic [7:0] addr, input logic [6:0] cnt,
                           input logic [7:0] data);
    reg_address = addr;
    reg_bytecnt = cnt;
    reg_datai   = data;
    reg_write   = 1'b1;
    idle_cycle();
    reg_write   = 1'b0;
  endtask

  // Data is registered, so it is on reg_datao right after the read edge
  task automatic read_reg(input logic [7:0] addr, input logic [6:0] cnt,
                          output logic [7:0] data);
    reg_address = addr;
    reg_bytecnt = cnt;
    reg_read    = 1'b1;
    idle_cycle();
    reg_read    = 1'b0;
    data        = reg_datao;
  endtask

  // Entered in the den cycle where the done bit still holds its old value
  task automatic wait_done(input bit idx);
    logic [7:0] st;
    int         polls;
    polls = 0;
    idle_cycle();
    read_reg(DRP_STATUS, 7'd0, st);
    while (!st[idx]) begin
      polls++;
      if (polls > DONE_TIMEOUT) begin
        $display("Timeout: MMCM%0d done bit never set in DRP_STATUS after %0d polls",
                 idx, polls);
        fail_run();
      end
      read_reg(DRP_STATUS, 7'd0, st);
    end
  endtask

  task automatic drp_write(input bit idx, input logic [6:0] a, input logic [15:0] w);
    logic [7:0] got;
    write_reg(data_reg_of(idx), 7'd0, w[7:0]);
    write_reg(data_reg_of(idx), 7'd1, w[15:8]);
    write_reg(addr_reg_of(idx), 7'd0, {1'b1, a});    // Bit 7 set, write command
    wait_done(idx);
    model[idx][a] = w;
    written.push_back({idx, a});
    read_reg(addr_reg_of(idx), 7'd0, got);           // Command bit must read 0
    check_byte($sformatf("reg_datao MMCM%0d DRP_ADDR", idx), {1'b0, a}, got);
  endtask

  task automatic drp_read_check(input bit idx, input logic [6:0] a);
    logic [7:0] got;
    write_reg(addr_reg_of(idx), 7'd0, {1'b0, a});    // Read command
    wait_done(idx);
    read_reg(data_reg_of(idx), 7'd0, got);
    check_byte($sformatf("reg_datao MMCM%0d word %02h byte 0", idx, a), model[idx][a][7:0], got);
    read_reg(data_reg_of(idx), 7'd1, got);
    check_byte($sformatf("reg_datao MMCM%0d word %02h byte 1", idx, a), model[idx][a][15:8], got);
  endtask

  // Done bit drops after den and comes back while the other bit stays put
  task automatic check_status_timing(input bit idx);
    logic [7:0]  st;
    logic [7:0]  exp;
    logic [15:0] tmp;
    exp = 8'h03;                                     // Both earlier commands completed
    read_reg(DRP_STATUS, 7'd0, st);
    check_byte($sformatf("reg_datao DRP_STATUS before MMCM%0d command", idx), exp, st);
    take_bits(7, tmp);
    write_reg(addr_reg_of(idx), 7'd0, {1'b0, tmp[6:0]});
    idle_cycle();                                    // Skip den cycle
    read_reg(DRP_STATUS, 7'd0, st);
    exp[idx] = 1'b0;
    check_byte($sformatf("reg_datao DRP_STATUS after MMCM%0d command", idx), exp, st);
    wait_done(idx);
    read_reg(DRP_STATUS, 7'd0, st);
    exp[idx] = 1'b1;
    check_byte($sformatf("reg_datao DRP_STATUS after MMCM%0d done", idx), exp, st);
  endtask

  initial begin
    logic [7:0]  got;
    logic [15:0] tmp;
    logic [15:0] w0;
    logic [6:0]  a;
    bit          idx;
    clk_usb     = 1'b0;
    reset_i     = 1'b1;
    reg_address = '0;
    reg_bytecnt = '0;
    reg_datai   = '0;
    reg_read    = 1'b0;
    reg_write   = 1'b0;
    for (int m = 0; m < 2; m++) begin
      for (int k = 0; k < 128; k++) begin
        model[m][k] = '0;                            // Stores clear on reset
      end
    end
    repeat (5) @(posedge clk_usb);
    #1;
    reset_i = 1'b0;

    // Reset state
    check_byte("reg_datao after reset", 8'h00, reg_datao);
    read_reg(DRP_STATUS, 7'd0, got);
    check_byte("reg_datao DRP_STATUS after reset", 8'h00, got);
    for (int m = 0; m < 2; m++) begin
      idx = m[0];
      read_reg(data_reg_of(idx), 7'd0, got);
      check_byte($sformatf("reg_datao MMCM%0d read hold after reset", idx), 8'h00, got);
      read_reg(addr_reg_of(idx), 7'd0, got);
      check_byte($sformatf("reg_datao MMCM%0d DRP_ADDR after reset", idx), 8'h00, got);
    end

    // Random write then read back on both clock managers
    for (int r = 0; r < RAND_ROUNDS; r++) begin
      for (int m = 0; m < 2; m++) begin
        idx = m[0];
        take_bits(7, tmp);
        a = tmp[6:0];
        take_bits(16, w0);
        drp_write(idx, a, w0);
        drp_read_check(idx, a);
      end
    end

    // Same DRP address, different words
    take_bits(7, tmp);
    a = tmp[6:0];
    take_bits(16, w0);
    drp_write(1'b0, a, w0);
    drp_write(1'b1, a, ~w0);
    drp_read_check(1'b0, a);
    drp_read_check(1'b1, a);

    check_status_timing(1'b0);
    check_status_timing(1'b1);

    // Everything written so far must still be there
    foreach (written[k]) begin
      drp_read_check(written[k][7], written[k][6:0]);
    end

    // Decode holes
    read_reg(8'h00, 7'd0, got);
    check_byte("reg_datao unmapped 0x00", 8'h00, got);
    read_reg(8'h5F, 7'd0, got);
    check_byte("reg_datao unmapped 0x5F", 8'h00, got);
    read_reg(8'h65, 7'd0, got);
    check_byte("reg_datao unmapped 0x65", 8'h00, got);
    read_reg(8'hFF, 7'd0, got);
    check_byte("reg_datao unmapped 0xFF", 8'h00, got);
    read_reg(MMCM0_DRP_DATA, 7'd2, got);             // Past the DRP word
    check_byte("reg_datao MMCM0 data byte 2", 8'h00, got);

    repeat (3) idle_cycle();
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- clkcfg.f
hw/clkcfg_reg_pkg.sv
hw/clkcfg_drp_pkg.sv
hw/drp_if.sv
hw/reg_mmcm_drp.sv
hw/drp_cfg_store.sv
hw/reg_readback_merge.sv
hw/clkcfg_top.sv
verif/clkcfg_tb.sv

//--- Makefile
# Verilator build and run of the clock configuration testbench

VERILATOR ?= verilator
TOP       ?= clkcfg_tb
FILELIST  ?= clkcfg.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
